// File: common/ooo_pkg.sv
// shared widths, sizes, opcodes and the alu function
// for the out-of-order back end
`default_nettype none

package ooo_pkg;

	// datapath and register file
	localparam int XLEN = 32;
	localparam int NUM_REGS = 8;
	localparam int REG_IDX_W = $clog2(NUM_REGS);
	localparam int IMM_W = 16;
	localparam int SHAMT_W = 5;

	// queue sizes, all powers of two so pointers wrap on their own
	localparam int ROB_DEPTH = 8;
	localparam int ROB_TAG_W = $clog2(ROB_DEPTH);
	localparam int RS_DEPTH = 4;
	localparam int RS_IDX_W = $clog2(RS_DEPTH);
	// input buffer depth, also the sender's starting credit
	localparam int INPUT_DEPTH = 4;
	localparam int INPUT_IDX_W = $clog2(INPUT_DEPTH);

	typedef logic [XLEN-1:0] data_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;
	typedef logic [ROB_TAG_W-1:0] rob_tag_t;
	typedef logic [IMM_W-1:0] imm_t;

	// encodings match the pattern file
	typedef enum logic [2:0] {
		OP_LI  = 3'd0,
		OP_ADD = 3'd1,
		OP_SUB = 3'd2,
		OP_AND = 3'd3,
		OP_OR  = 3'd4,
		OP_XOR = 3'd5,
		OP_SLL = 3'd6,
		OP_SRL = 3'd7
	} opcode_t;

	// result of one operation, li zero-extends the immediate
	function automatic data_t alu_result(
		input opcode_t op,
		input data_t   a,
		input data_t   b,
		input imm_t    imm
	);
		logic [SHAMT_W-1:0] shamt;
		shamt = b[SHAMT_W-1:0];
		case (op)
			OP_LI:   alu_result = {{(XLEN-IMM_W){1'b0}}, imm};
			OP_ADD:  alu_result = a + b;
			OP_SUB:  alu_result = a - b;
			OP_AND:  alu_result = a & b;
			OP_OR:   alu_result = a | b;
			OP_XOR:  alu_result = a ^ b;
			OP_SLL:  alu_result = a << shamt;
			OP_SRL:  alu_result = a >> shamt;
			default: alu_result = '0;
		endcase
	endfunction

endpackage

`default_nettype wire

// File: logic/dispatch_ctrl.sv
// dispatch control with the credit-fed input buffer
// hands the oldest instruction to rob, rename and rs when both have room
`timescale 1ns/1ps
`default_nettype none

module dispatch_ctrl import ooo_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     inst_valid,
	input  opcode_t  inst_op,
	input  reg_idx_t inst_rd,
	input  reg_idx_t inst_rs1,
	input  reg_idx_t inst_rs2,
	input  imm_t     inst_imm,
	input  logic     rob_full,
	input  logic     rs_full,
	output logic     inst_credit,
	output logic     dispatch_en,
	output opcode_t  disp_op,
	output reg_idx_t disp_rd,
	output reg_idx_t disp_rs1,
	output reg_idx_t disp_rs2,
	output imm_t     disp_imm
);

	// buffer storage
	opcode_t  buf_op  [INPUT_DEPTH];
	reg_idx_t buf_rd  [INPUT_DEPTH];
	reg_idx_t buf_rs1 [INPUT_DEPTH];
	reg_idx_t buf_rs2 [INPUT_DEPTH];
	imm_t     buf_imm [INPUT_DEPTH];

	// fifo pointers, count needs one extra bit for full
	logic [INPUT_IDX_W-1:0] wr_ptr;
	logic [INPUT_IDX_W-1:0] rd_ptr;
	logic [INPUT_IDX_W:0]   count;

	////////////////////////////////////////////////////////////
	// head presentation and stall decision
	////////////////////////////////////////////////////////////

	// the only place the full flags are looked at
	assign dispatch_en = (count != '0) && !rob_full && !rs_full;

	assign disp_op  = buf_op[rd_ptr];
	assign disp_rd  = buf_rd[rd_ptr];
	assign disp_rs1 = buf_rs1[rd_ptr];
	assign disp_rs2 = buf_rs2[rd_ptr];
	assign disp_imm = buf_imm[rd_ptr];

	////////////////////////////////////////////////////////////
	// buffer write and bookkeeping
	////////////////////////////////////////////////////////////

	// sender only drives valid while holding a credit, so no full check
	always_ff @(posedge clock) begin
		if (inst_valid) begin
			buf_op[wr_ptr]  <= inst_op;
			buf_rd[wr_ptr]  <= inst_rd;
			buf_rs1[wr_ptr] <= inst_rs1;
			buf_rs2[wr_ptr] <= inst_rs2;
			buf_imm[wr_ptr] <= inst_imm;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			inst_credit <= 1'b0;
		end else begin
			if (inst_valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (dispatch_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({inst_valid, dispatch_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// one credit back per slot freed, a cycle after the dispatch edge
			inst_credit <= dispatch_en;
		end
	end

endmodule

`default_nettype wire

// File: rename/rename_table.sv
// register map table with busy bits and producer tags
// also holds the architectural register file written at commit
`timescale 1ns/1ps
`default_nettype none

module rename_table import ooo_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     dispatch_en,
	input  reg_idx_t disp_rd,
	input  reg_idx_t disp_rs1,
	input  reg_idx_t disp_rs2,
	input  rob_tag_t alloc_tag,
	input  logic     commit_valid,
	input  reg_idx_t commit_rd,
	input  rob_tag_t commit_tag,
	input  data_t    commit_value,
	output logic     rs1_busy,
	output rob_tag_t rs1_tag,
	output data_t    rs1_value,
	output logic     rs2_busy,
	output rob_tag_t rs2_tag,
	output data_t    rs2_value
);

	// per register state
	logic [NUM_REGS-1:0] busy;
	rob_tag_t            map_tag    [NUM_REGS];
	data_t               arch_value [NUM_REGS];

	// source lookups for the instruction at the buffer head
	assign rs1_busy  = busy[disp_rs1];
	assign rs1_tag   = map_tag[disp_rs1];
	assign rs1_value = arch_value[disp_rs1];
	assign rs2_busy  = busy[disp_rs2];
	assign rs2_tag   = map_tag[disp_rs2];
	assign rs2_value = arch_value[disp_rs2];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				busy[i]       <= 1'b0;
				map_tag[i]    <= '0;
				arch_value[i] <= '0;
			end
		end else begin
			if (commit_valid) begin
				arch_value[commit_rd] <= commit_value;
				// a younger writer keeps the mapping
				if (map_tag[commit_rd] == commit_tag) begin
					busy[commit_rd] <= 1'b0;
				end
			end
			// new mapping comes last so it wins over a commit to the same reg
			if (dispatch_en) begin
				busy[disp_rd]    <= 1'b1;
				map_tag[disp_rd] <= alloc_tag;
			end
		end
	end

endmodule

`default_nettype wire

// File: rob/reorder_buffer.sv
// reorder buffer, circular and retiring strictly in program order
// serves operand values of busy registers and drives the commit port
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer import ooo_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     dispatch_en,
	input  reg_idx_t disp_rd,
	input  rob_tag_t rs1_tag,
	input  rob_tag_t rs2_tag,
	input  logic     cdb_valid,
	input  rob_tag_t cdb_tag,
	input  data_t    cdb_value,
	output logic     rob_full,
	output rob_tag_t alloc_tag,
	output logic     rob_rs1_ready,
	output data_t    rob_rs1_value,
	output logic     rob_rs2_ready,
	output data_t    rob_rs2_value,
	output logic     commit_valid,
	output reg_idx_t commit_rd,
	output data_t    commit_value,
	output rob_tag_t commit_tag
);

	// entry fields
	reg_idx_t             ent_rd    [ROB_DEPTH];
	data_t                ent_value [ROB_DEPTH];
	logic [ROB_DEPTH-1:0] ent_ready;

	// pointers wrap naturally at ROB_DEPTH
	rob_tag_t         head;
	rob_tag_t         tail;
	logic [ROB_TAG_W:0] count;
	logic             retire;

	assign alloc_tag = tail;
	assign rob_full  = (count == (ROB_TAG_W+1)'(ROB_DEPTH));

	// head leaves once its result is in
	assign retire = (count != '0) && ent_ready[head];

	////////////////////////////////////////////////////////////
	// operand lookups
	////////////////////////////////////////////////////////////

	// a slot just retired keeps its value until reused,
	// covering the cycle before the map table sees the commit
	assign rob_rs1_ready = ent_ready[rs1_tag];
	assign rob_rs1_value = ent_value[rs1_tag];
	assign rob_rs2_ready = ent_ready[rs2_tag];
	assign rob_rs2_value = ent_value[rs2_tag];

	////////////////////////////////////////////////////////////
	// entry payload and commit outputs
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (dispatch_en) begin
			ent_rd[tail] <= disp_rd;
		end
		if (cdb_valid) begin
			ent_value[cdb_tag] <= cdb_value;
		end
		// commit payload follows the head every cycle
		commit_rd    <= ent_rd[head];
		commit_value <= ent_value[head];
		commit_tag   <= head;
	end

	////////////////////////////////////////////////////////////
	// pointers, ready flags, occupancy
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			head         <= '0;
			tail         <= '0;
			count        <= '0;
			ent_ready    <= '0;
			commit_valid <= 1'b0;
		end else begin
			commit_valid <= retire;
			if (dispatch_en) begin
				tail            <= tail + 1'b1;
				ent_ready[tail] <= 1'b0;
			end
			// broadcast tag is always an in-flight entry, never the new tail
			if (cdb_valid) begin
				ent_ready[cdb_tag] <= 1'b1;
			end
			if (retire) begin
				head <= head + 1'b1;
			end
			case ({dispatch_en, retire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rs/reservation_station.sv
// reservation station holding operations until both operands arrive
// snoops the cdb and issues the lowest ready entry each cycle
`timescale 1ns/1ps
`default_nettype none

module reservation_station import ooo_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     dispatch_en,
	input  opcode_t  disp_op,
	input  imm_t     disp_imm,
	input  rob_tag_t alloc_tag,
	input  logic     rs1_busy,
	input  rob_tag_t rs1_tag,
	input  data_t    rs1_value,
	input  logic     rs2_busy,
	input  rob_tag_t rs2_tag,
	input  data_t    rs2_value,
	input  logic     rob_rs1_ready,
	input  data_t    rob_rs1_value,
	input  logic     rob_rs2_ready,
	input  data_t    rob_rs2_value,
	input  logic     cdb_valid,
	input  rob_tag_t cdb_tag,
	input  data_t    cdb_value,
	output logic     rs_full,
	output logic     issue_valid,
	output opcode_t  issue_op,
	output data_t    issue_a,
	output data_t    issue_b,
	output imm_t     issue_imm,
	output rob_tag_t issue_tag
);

	// entry state
	logic [RS_DEPTH-1:0] ent_valid;
	opcode_t             ent_op  [RS_DEPTH];
	imm_t                ent_imm [RS_DEPTH];
	rob_tag_t            ent_tag [RS_DEPTH];
	// operand a from rs1, b from rs2
	data_t               a_val   [RS_DEPTH];
	rob_tag_t            a_tag   [RS_DEPTH];
	logic [RS_DEPTH-1:0] a_wait;
	data_t               b_val   [RS_DEPTH];
	rob_tag_t            b_tag   [RS_DEPTH];
	logic [RS_DEPTH-1:0] b_wait;

	logic [RS_DEPTH-1:0] ready;
	logic [RS_IDX_W-1:0] issue_idx;
	logic [RS_IDX_W-1:0] alloc_idx;
	logic                is_li;
	logic [XLEN:0]       res_a;
	logic [XLEN:0]       res_b;

	// {wait, value} for one source at dispatch
	// order: committed reg, finished rob entry, same-cycle broadcast
	function automatic logic [XLEN:0] resolve(
		input logic     busy,
		input data_t    reg_value,
		input rob_tag_t tag,
		input logic     rob_ready,
		input data_t    rob_value,
		input logic     bus_valid,
		input rob_tag_t bus_tag,
		input data_t    bus_value
	);
		if (!busy) begin
			resolve = {1'b0, reg_value};
		end else if (rob_ready) begin
			resolve = {1'b0, rob_value};
		end else if (bus_valid && bus_tag == tag) begin
			resolve = {1'b0, bus_value};
		end else begin
			resolve = {1'b1, {XLEN{1'b0}}};
		end
	endfunction

	////////////////////////////////////////////////////////////
	// dispatch side
	////////////////////////////////////////////////////////////

	// li has no register sources
	assign is_li = (disp_op == OP_LI);
	assign res_a = resolve(rs1_busy, rs1_value, rs1_tag, rob_rs1_ready, rob_rs1_value,
		cdb_valid, cdb_tag, cdb_value);
	assign res_b = resolve(rs2_busy, rs2_value, rs2_tag, rob_rs2_ready, rob_rs2_value,
		cdb_valid, cdb_tag, cdb_value);

	assign rs_full = &ent_valid;

	// lowest free slot
	always_comb begin
		alloc_idx = '0;
		for (int i = RS_DEPTH - 1; i >= 0; i--) begin
			if (!ent_valid[i]) begin
				alloc_idx = RS_IDX_W'(i);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// issue select
	////////////////////////////////////////////////////////////

	always_comb begin
		ready       = '0;
		issue_valid = 1'b0;
		issue_idx   = '0;
		for (int i = 0; i < RS_DEPTH; i++) begin
			ready[i] = ent_valid[i] && !a_wait[i] && !b_wait[i];
		end
		// scan downward so the lowest index wins
		for (int i = RS_DEPTH - 1; i >= 0; i--) begin
			if (ready[i]) begin
				issue_valid = 1'b1;
				issue_idx   = RS_IDX_W'(i);
			end
		end
	end

	assign issue_op  = ent_op[issue_idx];
	assign issue_a   = a_val[issue_idx];
	assign issue_b   = b_val[issue_idx];
	assign issue_imm = ent_imm[issue_idx];
	assign issue_tag = ent_tag[issue_idx];

	// occupancy, freed slot is never the one being filled
	always_ff @(posedge clock) begin
		if (reset) begin
			ent_valid <= '0;
		end else begin
			if (issue_valid) begin
				ent_valid[issue_idx] <= 1'b0;
			end
			if (dispatch_en) begin
				ent_valid[alloc_idx] <= 1'b1;
			end
		end
	end

	// operand capture from the cdb, then the new entry
	always_ff @(posedge clock) begin
		for (int i = 0; i < RS_DEPTH; i++) begin
			if (ent_valid[i] && a_wait[i] && cdb_valid && cdb_tag == a_tag[i]) begin
				a_val[i]  <= cdb_value;
				a_wait[i] <= 1'b0;
			end
			if (ent_valid[i] && b_wait[i] && cdb_valid && cdb_tag == b_tag[i]) begin
				b_val[i]  <= cdb_value;
				b_wait[i] <= 1'b0;
			end
		end
		if (dispatch_en) begin
			ent_op[alloc_idx]  <= disp_op;
			ent_imm[alloc_idx] <= disp_imm;
			ent_tag[alloc_idx] <= alloc_tag;
			a_val[alloc_idx]   <= res_a[XLEN-1:0];
			a_tag[alloc_idx]   <= rs1_tag;
			a_wait[alloc_idx]  <= !is_li && res_a[XLEN];
			b_val[alloc_idx]   <= res_b[XLEN-1:0];
			b_tag[alloc_idx]   <= rs2_tag;
			b_wait[alloc_idx]  <= !is_li && res_b[XLEN];
		end
	end

endmodule

`default_nettype wire

// File: logic/alu_pipe.sv
// two-stage alu feeding the common data bus
// takes one issue per cycle, result appears two cycles later
`timescale 1ns/1ps
`default_nettype none

module alu_pipe import ooo_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     issue_valid,
	input  opcode_t  issue_op,
	input  data_t    issue_a,
	input  data_t    issue_b,
	input  imm_t     issue_imm,
	input  rob_tag_t issue_tag,
	output logic     cdb_valid,
	output rob_tag_t cdb_tag,
	output data_t    cdb_value
);

	// stage 1 operand registers
	logic     s1_valid;
	opcode_t  s1_op;
	data_t    s1_a;
	data_t    s1_b;
	imm_t     s1_imm;
	rob_tag_t s1_tag;
	data_t    s1_result;

	assign s1_result = alu_result(s1_op, s1_a, s1_b, s1_imm);

	// payload stages
	always_ff @(posedge clock) begin
		s1_op     <= issue_op;
		s1_a      <= issue_a;
		s1_b      <= issue_b;
		s1_imm    <= issue_imm;
		s1_tag    <= issue_tag;
		// stage 2 broadcast
		cdb_tag   <= s1_tag;
		cdb_value <= s1_result;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			s1_valid  <= 1'b0;
			cdb_valid <= 1'b0;
		end else begin
			s1_valid  <= issue_valid;
			cdb_valid <= s1_valid;
		end
	end

endmodule

`default_nettype wire

// File: logic/ooo_core.sv
// out-of-order core top, credit-fed input to in-order commit
// connects dispatch control, rename, rob, rs and the alu pipe
`timescale 1ns/1ps
`default_nettype none

module ooo_core import ooo_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     inst_valid,
	input  opcode_t  inst_op,
	input  reg_idx_t inst_rd,
	input  reg_idx_t inst_rs1,
	input  reg_idx_t inst_rs2,
	input  imm_t     inst_imm,
	output logic     inst_credit,
	output logic     commit_valid,
	output reg_idx_t commit_rd,
	output data_t    commit_value
);

	// buffer head toward the allocators
	logic     dispatch_en;
	opcode_t  disp_op;
	reg_idx_t disp_rd;
	reg_idx_t disp_rs1;
	reg_idx_t disp_rs2;
	imm_t     disp_imm;
	logic     rob_full;
	logic     rs_full;
	rob_tag_t alloc_tag;

	// map table answers
	logic     rs1_busy;
	rob_tag_t rs1_tag;
	data_t    rs1_value;
	logic     rs2_busy;
	rob_tag_t rs2_tag;
	data_t    rs2_value;

	// rob answers and commit tag
	logic     rob_rs1_ready;
	data_t    rob_rs1_value;
	logic     rob_rs2_ready;
	data_t    rob_rs2_value;
	rob_tag_t commit_tag;

	// rs to alu
	logic     issue_valid;
	opcode_t  issue_op;
	data_t    issue_a;
	data_t    issue_b;
	imm_t     issue_imm;
	rob_tag_t issue_tag;

	// result broadcast
	logic     cdb_valid;
	rob_tag_t cdb_tag;
	data_t    cdb_value;

	// port names match the nets one to one
	dispatch_ctrl       u_dispatch (.*);
	rename_table        u_rename   (.*);
	reorder_buffer      u_rob      (.*);
	reservation_station u_rs       (.*);
	alu_pipe            u_alu      (.*);

endmodule

`default_nettype wire

// File: tb/ooo_core_chk.sv
// dispatch control checks bound into dispatch_ctrl
// buffer overflow, full flag timing and credit room
`timescale 1ns/1ps
`default_nettype none

module ooo_core_chk import ooo_pkg::*; (
	input logic                 clock,
	input logic                 reset,
	input logic                 inst_valid,
	input logic [INPUT_IDX_W:0] count,
	input logic                 dispatch_en,
	input logic                 rob_full,
	input logic                 rs_full,
	input logic                 inst_credit
);

	// sender writes only into a free slot
	no_overflow: assert property (@(posedge clock) disable iff (reset)
		inst_valid |-> count < (INPUT_IDX_W+1)'(INPUT_DEPTH))
		else $error("input buffer written while full");

	// rob or rs fills up only through an allocation
	full_rises_on_dispatch: assert property (@(posedge clock) disable iff (reset)
		$rose(rob_full) || $rose(rs_full) |-> $past(dispatch_en))
		else $error("rob or rs became full without a dispatch");

	// a returned credit always stands for a free slot
	credit_means_room: assert property (@(posedge clock) disable iff (reset)
		inst_credit |-> count < (INPUT_IDX_W+1)'(INPUT_DEPTH))
		else $error("credit returned while the input buffer is full");

endmodule

bind dispatch_ctrl ooo_core_chk u_chk (
	.clock(clock),
	.reset(reset),
	.inst_valid(inst_valid),
	.count(count),
	.dispatch_en(dispatch_en),
	.rob_full(rob_full),
	.rs_full(rs_full),
	.inst_credit(inst_credit)
);

`default_nettype wire

// File: tb/ooo_core_tb.sv
// testbench for the out-of-order core
// credit-honoring sender fed from the pattern file, in-order commit checker
`timescale 1ns/1ps
`default_nettype none

module ooo_core_tb import ooo_pkg::*; ();

	localparam string PATTERN_FILE = "tb/ooo_core_patterns.txt";
	localparam int MAX_PATTERNS = 64;
	// patterns from here on go out back to back
	localparam int BURST_START = 10;

	logic     clock;
	logic     reset;
	logic     inst_valid;
	opcode_t  inst_op;
	reg_idx_t inst_rd;
	reg_idx_t inst_rs1;
	reg_idx_t inst_rs2;
	imm_t     inst_imm;
	logic     inst_credit;
	logic     commit_valid;
	reg_idx_t commit_rd;
	data_t    commit_value;

	// stimulus table and expected commits in file order
	opcode_t  pat_op  [MAX_PATTERNS];
	reg_idx_t pat_rd  [MAX_PATTERNS];
	reg_idx_t pat_rs1 [MAX_PATTERNS];
	reg_idx_t pat_rs2 [MAX_PATTERNS];
	imm_t     pat_imm [MAX_PATTERNS];
	reg_idx_t exp_rd  [$];
	data_t    exp_val [$];

	int       num_patterns = 0;
	int       idx = 0;
	int       credits = 0;
	int       credit_pulses = 0;
	int       sent = 0;
	int       commits_seen = 0;
	int       mismatches = 0;
	int       failures = 0;
	logic     loaded = 1'b0;
	logic [7:0] lfsr;

	ooo_core UUT (.*);

	always #20 clock = ~clock;

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	// fibonacci lfsr, taps 8 6 5 4
	function automatic logic next_random_bit();
		logic fb;
		fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
		next_random_bit = lfsr[7];
		lfsr = {lfsr[6:0], fb};
	endfunction

	task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
			mismatches++;
		end
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
			mismatches++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
			mismatches++;
		end
	endtask

	// six hex columns per line, lines starting with # skipped
	task automatic load_patterns();
		int fd;
		int n;
		string line;
		logic [31:0] f_op, f_rd, f_rs1, f_rs2, f_imm, f_val;
		n = 0;
		fd = $fopen(PATTERN_FILE, "r");
		if (fd == 0) begin
			$display("cannot open pattern file %s", PATTERN_FILE);
			failures++;
		end else begin
			while ($fgets(line, fd) > 0) begin
				if (line.len() > 0 && line.getc(0) != "#" && n < MAX_PATTERNS &&
						$sscanf(line, "%h %h %h %h %h %h",
						f_op, f_rd, f_rs1, f_rs2, f_imm, f_val) == 6) begin
					pat_op[n]  = opcode_t'(f_op[2:0]);
					pat_rd[n]  = f_rd[REG_IDX_W-1:0];
					pat_rs1[n] = f_rs1[REG_IDX_W-1:0];
					pat_rs2[n] = f_rs2[REG_IDX_W-1:0];
					pat_imm[n] = f_imm[IMM_W-1:0];
					exp_rd.push_back(f_rd[REG_IDX_W-1:0]);
					exp_val.push_back(f_val);
					n++;
				end
			end
			$fclose(fd);
			if (n == 0) begin
				$display("pattern file holds no instructions");
				failures++;
			end
		end
		num_patterns = n;
	endtask

	task automatic check_idle_outputs();
		check_flag("commit_valid", commit_valid, 1'b0);
		check_flag("inst_credit", inst_credit, 1'b0);
	endtask

	// credits and commits, sampled mid-cycle
	task automatic watch_outputs();
		if (inst_credit === 1'b1) begin
			credits++;
			credit_pulses++;
		end
		if (credits > INPUT_DEPTH) begin
			$display("sender credit count %0d above %0d at %0t", credits, INPUT_DEPTH, $time);
			failures++;
		end
		if (commit_valid === 1'b1) begin
			if (exp_rd.size() == 0) begin
				$display("commit to r%0d with nothing expected at %0t", commit_rd, $time);
				failures++;
			end else begin
				check_reg("commit_rd", commit_rd, exp_rd.pop_front());
				check_data("commit_value", commit_value, exp_val.pop_front());
				commits_seen++;
			end
		end
	endtask

	// one instruction per credit, random gaps before the burst
	task automatic drive_next();
		logic send;
		send = (idx < num_patterns) && (credits > 0);
		if (send && idx < BURST_START) begin
			send = !next_random_bit();
		end
		if (send) begin
			inst_valid <= 1'b1;
			inst_op    <= pat_op[idx];
			inst_rd    <= pat_rd[idx];
			inst_rs1   <= pat_rs1[idx];
			inst_rs2   <= pat_rs2[idx];
			inst_imm   <= pat_imm[idx];
			credits--;
			idx++;
			sent++;
		end else begin
			inst_valid <= 1'b0;
		end
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		clock      = 1'b0;
		reset      = 1'b1;
		inst_valid = 1'b0;
		inst_op    = OP_LI;
		inst_rd    = '0;
		inst_rs1   = '0;
		inst_rs2   = '0;
		inst_imm   = '0;
		lfsr       = 8'd26;
		load_patterns();
		loaded = 1'b1;
		// three reset cycles, outputs quiet throughout
		@(posedge clock);
		repeat (2) begin
			@(negedge clock);
			check_idle_outputs();
			@(posedge clock);
		end
		reset <= 1'b0;
		@(negedge clock);
		check_idle_outputs();
		credits = INPUT_DEPTH;
		while (commits_seen < num_patterns) begin
			@(posedge clock);
			drive_next();
			@(negedge clock);
			watch_outputs();
		end
		// quiet tail catches extra commits or late credits
		repeat (8) begin
			@(negedge clock);
			watch_outputs();
		end
		if (credit_pulses != sent) begin
			$display("%0d credit pulses for %0d instructions sent", credit_pulses, sent);
			failures++;
		end
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// watchdog, 40 cycles per pattern plus slack
	initial begin
		wait (loaded);
		repeat (num_patterns * 40 + 100) @(posedge clock);
		$display("timeout with %0d of %0d commits seen", commits_seen, num_patterns);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/ooo_core_patterns.txt
# op rd rs1 rs2 imm expected_value, all hex; op 0 li 1 add 2 sub 3 and 4 or 5 xor 6 sll 7 srl
# first ten lines have random gaps, the last twelve are one dependent burst
0 1 0 0 1234 00001234
0 2 0 0 0005 00000005
1 3 1 2 0000 00001239
6 4 3 2 0000 00024720
2 3 4 1 0000 000234ec
5 5 3 1 0000 000226d8
0 3 0 0 ffff 0000ffff
3 6 3 5 0000 000026d8
7 7 4 2 0000 00001239
4 0 6 7 0000 000036f9
0 1 0 0 0001 00000001
1 1 1 1 0000 00000002
1 2 1 1 0000 00000004
1 1 2 1 0000 00000006
6 3 1 2 0000 00000060
2 4 3 1 0000 0000005a
5 5 4 3 0000 0000003a
4 6 5 2 0000 0000003e
3 7 6 4 0000 0000001a
7 0 4 2 0000 00000005
2 1 0 6 0000 ffffffc7
1 2 1 7 0000 ffffffe1

// File: ooo_core.f
common/ooo_pkg.sv
logic/dispatch_ctrl.sv
rename/rename_table.sv
rob/reorder_buffer.sv
rs/reservation_station.sv
logic/alu_pipe.sv
logic/ooo_core.sv
tb/ooo_core_chk.sv
tb/ooo_core_tb.sv

// File: Makefile
# verilator flow for the out-of-order core testbench
TOP := ooo_core_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f ooo_core.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

lint:
	verilator --lint-only --timing -Wall --top-module ooo_core -f ooo_core.f

clean:
	rm -rf obj_dir
